// File: rtl/vidout_pkg.sv
// Shared types and constants for the output video path.
// Import into a module body where the definitions are needed.
`default_nettype none

package vidout_pkg;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
    } sync_t;

    // Expansion connector use
    typedef enum logic [1:0] {
        EXP_SEL_OFF       = 2'd0,
        EXP_SEL_EXTRA_OUT = 2'd1,
        EXP_SEL_LEGACY_IN = 2'd2,
        EXP_SEL_UVC_BDG   = 2'd3
    } exp_sel_t;

    // Order is significant, RGsB and above carry sync on green
    typedef enum logic [1:0] {
        EXTRA_OUT_RGBHV = 2'd0,
        EXTRA_OUT_RGBCS = 2'd1,
        EXTRA_OUT_RGSB  = 2'd2,
        EXTRA_OUT_YPBPR = 2'd3
    } extra_out_mode_t;

    typedef logic [1:0] osd_color_t;

    localparam rgb_t OSD_PALETTE [4] = '{
        '{r: 8'h00, g: 8'h00, b: 8'h00},
        '{r: 8'h00, g: 8'h00, b: 8'hff},
        '{r: 8'hff, g: 8'hff, b: 8'h00},
        '{r: 8'hff, g: 8'hff, b: 8'hff}
    };

    localparam int APB_ADDR_W = 8;
    localparam logic [APB_ADDR_W-1:0] CTRL_ADDR = 8'h00;

    // Control register layout
    localparam int CTRL_POWERON_BIT = 0;
    localparam int CTRL_EXP_SEL_LSB = 1;
    localparam int CTRL_EXP_SEL_W   = 2;
    localparam int CTRL_MODE_LSB    = 3;
    localparam int CTRL_MODE_W      = 2;

endpackage

`default_nettype wire

// File: rtl/vidout_apb_regs.sv
// APB3 slave with the output control register.
// Zero wait states; unmapped offsets complete with an error response.
`timescale 1ns/1ps
`default_nettype none

module vidout_apb_regs (
    input  wire                                pclk_out,
    input  wire                                po_reset_n,
    input  wire                                psel_i,
    input  wire                                penable_i,
    input  wire                                pwrite_i,
    input  wire [vidout_pkg::APB_ADDR_W-1:0]   paddr_i,
    input  wire [31:0]                         pwdata_i,
    output logic [31:0]                        prdata_o,
    output logic                               pready_o,
    output logic                               pslverr_o,
    output logic                               poweron_o,
    output vidout_pkg::exp_sel_t               exp_sel_o,
    output vidout_pkg::extra_out_mode_t        mode_o
);

    import vidout_pkg::*;

    logic access;
    logic ctrl_hit;
    logic ctrl_wr;
    logic [31:0] ctrl_word;

    assign access   = psel_i & penable_i;
    assign ctrl_hit = (paddr_i == CTRL_ADDR);
    assign ctrl_wr  = access & pwrite_i & ctrl_hit;

    // No wait states
    assign pready_o  = access;
    assign pslverr_o = access & ~ctrl_hit;

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            poweron_o <= 1'b0;
            exp_sel_o <= EXP_SEL_OFF;
            mode_o    <= EXTRA_OUT_RGBHV;
        end else if (ctrl_wr) begin
            poweron_o <= pwdata_i[CTRL_POWERON_BIT];
            exp_sel_o <= exp_sel_t'(pwdata_i[CTRL_EXP_SEL_LSB +: CTRL_EXP_SEL_W]);
            mode_o    <= extra_out_mode_t'(pwdata_i[CTRL_MODE_LSB +: CTRL_MODE_W]);
        end
    end

    // Reserved bits stay zero
    always_comb begin
        ctrl_word = '0;
        ctrl_word[CTRL_POWERON_BIT] = poweron_o;
        ctrl_word[CTRL_EXP_SEL_LSB +: CTRL_EXP_SEL_W] = exp_sel_o;
        ctrl_word[CTRL_MODE_LSB +: CTRL_MODE_W] = mode_o;
    end

    always_comb begin
        if (psel_i && !pwrite_i && ctrl_hit) begin
            prdata_o = ctrl_word;
        end else begin
            prdata_o = '0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/osd_overlay.sv
// First output stage. Registers the scaled pixel and swaps in an
// OSD palette colour where the OSD marks it; syncs follow with the same delay.
`timescale 1ns/1ps
`default_nettype none

module osd_overlay (
    input  wire                         pclk_out,
    input  wire                         po_reset_n,
    input  vidout_pkg::rgb_t            rgb_i,
    input  vidout_pkg::sync_t           sync_i,
    input  wire                         osd_enable_i,
    input  vidout_pkg::osd_color_t      osd_color_i,
    output vidout_pkg::rgb_t            rgb_o,
    output vidout_pkg::sync_t           sync_o
);

    import vidout_pkg::*;

    rgb_t pix_sel;

    always_comb begin
        if (osd_enable_i) begin
            pix_sel = OSD_PALETTE[osd_color_i];
        end else begin
            pix_sel = rgb_i;
        end
    end

    // Pixel data
    always_ff @(posedge pclk_out) begin
        rgb_o <= pix_sel;
    end

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            sync_o <= '0;
        end else begin
            sync_o <= sync_i;
        end
    end

endmodule

`default_nettype wire

// File: rtl/hdmi_tx_stage.sv
// Launch register towards the HDMI transmitter.
// Kept as its own stage for output timing closure.
`timescale 1ns/1ps
`default_nettype none

module hdmi_tx_stage (
    input  wire                 pclk_out,
    input  wire                 po_reset_n,
    input  vidout_pkg::rgb_t    rgb_i,
    input  vidout_pkg::sync_t   sync_i,
    output vidout_pkg::rgb_t    hdmi_rgb_o,
    output vidout_pkg::sync_t   hdmi_sync_o
);

    always_ff @(posedge pclk_out) begin
        hdmi_rgb_o <= rgb_i;
    end

    // Transmitter sees syncs and DE low while in reset
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            hdmi_sync_o <= '0;
        end else begin
            hdmi_sync_o <= sync_i;
        end
    end

endmodule

`default_nettype wire

// File: rtl/vga_dac_fmt.sv
// Expansion connector analog output formatter for the VGA DAC.
// Two register stages; sync, blank and sync-on-green follow the output mode.
`timescale 1ns/1ps
`default_nettype none

module vga_dac_fmt (
    input  wire                             pclk_out,
    input  wire                             po_reset_n,
    input  vidout_pkg::rgb_t                rgb_i,
    input  vidout_pkg::sync_t               sync_i,
    input  vidout_pkg::exp_sel_t            exp_sel_i,
    input  vidout_pkg::extra_out_mode_t     mode_i,
    output vidout_pkg::rgb_t                vga_rgb_o,
    output logic                            vga_hs_o,
    output logic                            vga_vs_o,
    output logic                            vga_blank_n_o,
    output logic                            vga_sync_n_o
);

    import vidout_pkg::*;

    logic load;
    logic csync;
    rgb_t rgb_pre;
    logic hs_pre;
    logic vs_pre;
    logic blank_n_pre;
    logic sync_n_pre;

    // Registers freeze while the connector is used for something else
    assign load  = (exp_sel_i == EXP_SEL_EXTRA_OUT);
    assign csync = ~(sync_i.hsync ^ sync_i.vsync);

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            rgb_pre     <= '0;
            hs_pre      <= 1'b0;
            vs_pre      <= 1'b0;
            blank_n_pre <= 1'b0;
            sync_n_pre  <= 1'b0;
        end else if (load) begin
            rgb_pre     <= rgb_i;
            hs_pre      <= (mode_i == EXTRA_OUT_RGBHV) ? sync_i.hsync : csync;
            vs_pre      <= (mode_i == EXTRA_OUT_RGBHV) ? sync_i.vsync : 1'b1;
            // YPbPr keeps the DAC unblanked
            blank_n_pre <= (mode_i == EXTRA_OUT_YPBPR) ? 1'b1 : sync_i.de;
            sync_n_pre  <= (mode_i >= EXTRA_OUT_RGSB) ? csync : 1'b0;
        end
    end

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            vga_rgb_o     <= '0;
            vga_hs_o      <= 1'b0;
            vga_vs_o      <= 1'b0;
            vga_blank_n_o <= 1'b0;
            vga_sync_n_o  <= 1'b0;
        end else if (load) begin
            vga_rgb_o     <= rgb_pre;
            vga_hs_o      <= hs_pre;
            vga_vs_o      <= vs_pre;
            vga_blank_n_o <= blank_n_pre;
            vga_sync_n_o  <= sync_n_pre;
        end
    end

endmodule

`default_nettype wire

// File: rtl/vidout_top.sv
// Output video path top level on pclk_out.
// OSD overlay feeds the HDMI launch stage and the VGA DAC formatter.
`timescale 1ns/1ps
`default_nettype none

module vidout_top (
    input  wire                                 pclk_out,
    input  wire                                 po_reset_n,
    input  wire                                 psel_i,
    input  wire                                 penable_i,
    input  wire                                 pwrite_i,
    input  wire [vidout_pkg::APB_ADDR_W-1:0]    paddr_i,
    input  wire [31:0]                          pwdata_i,
    output logic [31:0]                         prdata_o,
    output logic                                pready_o,
    output logic                                pslverr_o,
    input  vidout_pkg::rgb_t                    rgb_i,
    input  vidout_pkg::sync_t                   sync_i,
    input  wire                                 osd_enable_i,
    input  vidout_pkg::osd_color_t              osd_color_i,
    output vidout_pkg::rgb_t                    hdmi_rgb_o,
    output vidout_pkg::sync_t                   hdmi_sync_o,
    output logic                                hdmi_5v_en_o,
    output vidout_pkg::rgb_t                    vga_rgb_o,
    output logic                                vga_hs_o,
    output logic                                vga_vs_o,
    output logic                                vga_blank_n_o,
    output logic                                vga_sync_n_o,
    output logic                                vga_oe_o,
    output logic                                vga_psave_n_o
);

    import vidout_pkg::*;

    logic            poweron;
    exp_sel_t        exp_sel;
    extra_out_mode_t mode;
    rgb_t            ovl_rgb;
    sync_t           ovl_sync;

    vidout_apb_regs u_regs (
        .pclk_out   (pclk_out),
        .po_reset_n (po_reset_n),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .pwrite_i   (pwrite_i),
        .paddr_i    (paddr_i),
        .pwdata_i   (pwdata_i),
        .prdata_o   (prdata_o),
        .pready_o   (pready_o),
        .pslverr_o  (pslverr_o),
        .poweron_o  (poweron),
        .exp_sel_o  (exp_sel),
        .mode_o     (mode)
    );

    osd_overlay u_osd (
        .pclk_out     (pclk_out),
        .po_reset_n   (po_reset_n),
        .rgb_i        (rgb_i),
        .sync_i       (sync_i),
        .osd_enable_i (osd_enable_i),
        .osd_color_i  (osd_color_i),
        .rgb_o        (ovl_rgb),
        .sync_o       (ovl_sync)
    );

    hdmi_tx_stage u_hdmi (
        .pclk_out    (pclk_out),
        .po_reset_n  (po_reset_n),
        .rgb_i       (ovl_rgb),
        .sync_i      (ovl_sync),
        .hdmi_rgb_o  (hdmi_rgb_o),
        .hdmi_sync_o (hdmi_sync_o)
    );

    vga_dac_fmt u_vga (
        .pclk_out      (pclk_out),
        .po_reset_n    (po_reset_n),
        .rgb_i         (ovl_rgb),
        .sync_i        (ovl_sync),
        .exp_sel_i     (exp_sel),
        .mode_i        (mode),
        .vga_rgb_o     (vga_rgb_o),
        .vga_hs_o      (vga_hs_o),
        .vga_vs_o      (vga_vs_o),
        .vga_blank_n_o (vga_blank_n_o),
        .vga_sync_n_o  (vga_sync_n_o)
    );

    // Board power controls
    assign hdmi_5v_en_o  = poweron;
    assign vga_psave_n_o = poweron;

    // Expansion pins drive only in extra output mode
    assign vga_oe_o = (exp_sel == EXP_SEL_EXTRA_OUT);

endmodule

`default_nettype wire

// File: verif/vidout_props.sv
// Concurrent checks on the output path top level.
// Bound into every vidout_top instance; failures counted for the testbench.
`timescale 1ns/1ps
`default_nettype none

module vidout_props (
    input  wire                                 pclk_out,
    input  wire                                 po_reset_n,
    input  wire                                 psel_i,
    input  wire                                 penable_i,
    input  wire                                 pwrite_i,
    input  wire [vidout_pkg::APB_ADDR_W-1:0]    paddr_i,
    input  wire [31:0]                          pwdata_i,
    input  wire                                 pready_o,
    input  wire                                 vga_oe_o,
    input  vidout_pkg::sync_t                   hdmi_sync_o
);

    import vidout_pkg::*;

    int fail_cnt = 0;

    // Zero wait states
    a_pready: assert property (@(posedge pclk_out) disable iff (!po_reset_n)
        (psel_i && penable_i) |-> pready_o)
    else begin
        $error("pready_o low in an APB access cycle");
        fail_cnt++;
    end

    // Connector enable taken from the exp_sel field of a completed CTRL write
    a_oe: assert property (@(posedge pclk_out) disable iff (!po_reset_n)
        (psel_i && penable_i && pwrite_i && paddr_i == CTRL_ADDR)
        |=> vga_oe_o == ($past(pwdata_i[CTRL_EXP_SEL_LSB +: CTRL_EXP_SEL_W])
                         == EXP_SEL_EXTRA_OUT))
    else begin
        $error("vga_oe_o does not follow exp_sel");
        fail_cnt++;
    end

    a_hdmi_rst: assert property (@(posedge pclk_out)
        !po_reset_n |-> (hdmi_sync_o == '0))
    else begin
        $error("hdmi_sync_o not low during reset");
        fail_cnt++;
    end

endmodule

bind vidout_top vidout_props u_props (
    .pclk_out    (pclk_out),
    .po_reset_n  (po_reset_n),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .pready_o    (pready_o),
    .vga_oe_o    (vga_oe_o),
    .hdmi_sync_o (hdmi_sync_o)
);

`default_nettype wire

// File: verif/tb_clkgen.sv
// Clock and power-on reset for the output path testbench.
// 100 ns clock period; reset held low for the first 16 rising edges.
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic pclk_out,
    output logic po_reset_n
);

    localparam int RESET_CYC = 16;

    initial begin
        pclk_out = 1'b0;
        forever #50 pclk_out = ~pclk_out;
    end

    initial begin
        // Clean falling edge at time zero for the async reset flops
        po_reset_n <= 1'b0;
        repeat (RESET_CYC) @(posedge pclk_out);
        #25;
        po_reset_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: verif/tb_vidout.sv
// Testbench for the output video path. Random pixels, syncs and OSD flags
// stream through the DUT while an APB driver rewrites the control register.
`timescale 1ns/1ps
`default_nettype none

module tb_vidout;

    import vidout_pkg::*;

    localparam logic [31:0] SEED      = 32'h97a571ba;
    localparam logic [31:0] CTRL_MASK = 32'h0000_001f;
    localparam int RESET_CYC = 16;
    localparam int N_REG     = 24;
    localparam int MODE_CYC  = 150;
    localparam int HOLD_CYC  = 40;
    // Three clocks per APB transfer, five transfers per register round
    localparam int TIMEOUT_CYC = RESET_CYC + 16 + N_REG * 5 * 3 + 4 * (MODE_CYC + 3)
                                 + HOLD_CYC + 24 + 200;

    logic pclk_out;
    logic po_reset_n;
    logic psel_i;
    logic penable_i;
    logic pwrite_i;
    logic [APB_ADDR_W-1:0] paddr_i;
    logic [31:0] pwdata_i;
    logic [31:0] prdata_o;
    logic pready_o;
    logic pslverr_o;
    rgb_t rgb_i;
    sync_t sync_i;
    logic osd_enable_i;
    osd_color_t osd_color_i;
    rgb_t hdmi_rgb_o;
    sync_t hdmi_sync_o;
    logic hdmi_5v_en_o;
    rgb_t vga_rgb_o;
    logic vga_hs_o;
    logic vga_vs_o;
    logic vga_blank_n_o;
    logic vga_sync_n_o;
    logic vga_oe_o;
    logic vga_psave_n_o;

    integer video_seed;
    integer reg_seed;
    logic video_on;
    int cycles = 0;
    int warm;
    logic [31:0] ctrl_model;
    logic [31:0] ctrl_prev;
    rgb_t hist_rgb [2];
    sync_t hist_sync [2];
    rgb_t m_pre_rgb;
    rgb_t m_out_rgb;
    logic [3:0] m_pre_flags;
    logic [3:0] m_out_flags;

    tb_clkgen clkgen0 (.pclk_out(pclk_out), .po_reset_n(po_reset_n));

    vidout_top dut0 (.*);

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("ERR %s got %h exp %h", name, got, exp));
        end
    endtask

    task automatic check_sync(input string name, input sync_t got, input sync_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("ERR %s got %h exp %h", name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("ERR %s got %h exp %h", name, got, exp));
        end
    endtask

    function automatic rgb_t overlay_pixel(input rgb_t pix, input logic en,
                                           input osd_color_t col);
        if (!en) begin
            return pix;
        end
        case (col)
            2'd0: return 24'h000000;
            2'd1: return 24'h0000ff;
            2'd2: return 24'hffff00;
            default: return 24'hffffff;
        endcase
    endfunction

    // Returns {hs, vs, blank_n, sync_n} for the DAC
    function automatic logic [3:0] vga_flags(input sync_t s, input extra_out_mode_t m);
        logic csync;
        logic hs;
        logic vs;
        logic blank_n;
        logic sync_n;
        csync   = ~(s.hsync ^ s.vsync);
        hs      = (m == EXTRA_OUT_RGBHV) ? s.hsync : csync;
        vs      = (m == EXTRA_OUT_RGBHV) ? s.vsync : 1'b1;
        blank_n = (m == EXTRA_OUT_YPBPR) ? 1'b1 : s.de;
        sync_n  = (m == EXTRA_OUT_RGSB || m == EXTRA_OUT_YPBPR) ? csync : 1'b0;
        return {hs, vs, blank_n, sync_n};
    endfunction

    function automatic logic [31:0] make_ctrl(input logic pwr, input exp_sel_t sel,
                                              input extra_out_mode_t m);
        return {27'd0, m, sel, pwr};
    endfunction

    task automatic apb_xfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
        @(posedge pclk_out);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= wr;
        paddr_i   <= addr;
        pwdata_i  <= wdata;
        @(posedge pclk_out);
        penable_i <= 1'b1;
        @(negedge pclk_out);
        while (!pready_o) begin
            @(negedge pclk_out);
        end
        rdata = prdata_o;
        err   = pslverr_o;
        // Completing edge
        @(posedge pclk_out);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic ctrl_write(input logic [31:0] data);
        logic [31:0] rdata;
        logic err;
        apb_xfer(1'b1, CTRL_ADDR, data, rdata, err);
        ctrl_model = data & CTRL_MASK;
        check_word("pslverr_o", err, 1'b0);
    endtask

    task automatic ctrl_read_check();
        logic [31:0] rdata;
        logic err;
        apb_xfer(1'b0, CTRL_ADDR, 32'h0, rdata, err);
        check_word("prdata_o", rdata, ctrl_model);
        check_word("pslverr_o", err, 1'b0);
    endtask

    always @(posedge pclk_out) begin
        logic [31:0] rnd;
        if (video_on) begin
            rnd = $random(video_seed);
            rgb_i        <= rnd[23:0];
            sync_i       <= rnd[26:24];
            osd_enable_i <= (rnd[29:28] == 2'b00);
            osd_color_i  <= rnd[31:30];
        end
    end

    // Model runs on the falling edge, where DUT outputs are settled
    always @(negedge pclk_out) begin
        if (po_reset_n !== 1'b1) begin
            m_pre_rgb   = '0;
            m_out_rgb   = '0;
            m_pre_flags = '0;
            m_out_flags = '0;
            warm        = 0;
        end else begin
            if (ctrl_prev[2:1] == EXP_SEL_EXTRA_OUT) begin
                m_out_rgb   = m_pre_rgb;
                m_out_flags = m_pre_flags;
                m_pre_rgb   = hist_rgb[1];
                m_pre_flags = vga_flags(hist_sync[1], extra_out_mode_t'(ctrl_prev[4:3]));
            end
            check_rgb("vga_rgb_o", vga_rgb_o, m_out_rgb);
            check_word("vga_hs_o", vga_hs_o, m_out_flags[3]);
            check_word("vga_vs_o", vga_vs_o, m_out_flags[2]);
            check_word("vga_blank_n_o", vga_blank_n_o, m_out_flags[1]);
            check_word("vga_sync_n_o", vga_sync_n_o, m_out_flags[0]);
            check_word("vga_oe_o", vga_oe_o, ctrl_model[2:1] == EXP_SEL_EXTRA_OUT);
            check_word("hdmi_5v_en_o", hdmi_5v_en_o, ctrl_model[0]);
            check_word("vga_psave_n_o", vga_psave_n_o, ctrl_model[0]);
            if (warm >= 3) begin
                check_rgb("hdmi_rgb_o", hdmi_rgb_o, hist_rgb[1]);
                check_sync("hdmi_sync_o", hdmi_sync_o, hist_sync[1]);
            end else begin
                warm = warm + 1;
            end
        end
        hist_rgb[1]  = hist_rgb[0];
        hist_rgb[0]  = overlay_pixel(rgb_i, osd_enable_i, osd_color_i);
        hist_sync[1] = hist_sync[0];
        hist_sync[0] = sync_i;
        ctrl_prev    = ctrl_model;
    end

    always @(posedge pclk_out) begin
        cycles = cycles + 1;
        if (dut0.u_props.fail_cnt != 0) begin
            $display("Bound assertion failed by cycle %0d", cycles);
            $display("Simulation failed");
            $fatal(1);
        end else if (cycles > TIMEOUT_CYC) begin
            $display("Timeout: tests still running after %0d cycles", cycles);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    initial begin
        logic [31:0] rdata;
        logic [31:0] data;
        logic err;
        logic [APB_ADDR_W-1:0] addr;
        rgb_t snap_rgb;
        logic [3:0] snap_flags;
        video_seed   = SEED;
        reg_seed     = ~SEED;
        video_on     = 1'b0;
        ctrl_model   = '0;
        ctrl_prev    = '0;
        psel_i       = 1'b0;
        penable_i    = 1'b0;
        pwrite_i     = 1'b0;
        paddr_i      = '0;
        pwdata_i     = '0;
        rgb_i        = '0;
        // Syncs held high through reset so the reset values show
        sync_i       = '1;
        osd_enable_i = 1'b0;
        osd_color_i  = '0;
        @(posedge po_reset_n);
        @(negedge pclk_out);
        check_sync("hdmi_sync_o", hdmi_sync_o, '0);
        check_word("vga_oe_o", vga_oe_o, 1'b0);
        check_word("hdmi_5v_en_o", hdmi_5v_en_o, 1'b0);
        check_word("vga_psave_n_o", vga_psave_n_o, 1'b0);
        ctrl_read_check();
        @(negedge pclk_out);
        video_on = 1'b1;

        // Readback with reserved bits, then unmapped offsets
        for (int i = 0; i < N_REG; i++) begin
            data = $random(reg_seed);
            ctrl_write(data);
            ctrl_read_check();
            data = $random(reg_seed);
            addr = data[APB_ADDR_W-1:0];
            if (addr == CTRL_ADDR) begin
                addr = 8'h04;
            end
            apb_xfer(1'b1, addr, $random(reg_seed), rdata, err);
            check_word("pslverr_o", err, 1'b1);
            apb_xfer(1'b0, addr, 32'h0, rdata, err);
            check_word("pslverr_o", err, 1'b1);
            ctrl_read_check();
        end

        for (int m = 0; m < 4; m++) begin
            ctrl_write(make_ctrl(1'b1, EXP_SEL_EXTRA_OUT, extra_out_mode_t'(m)));
            repeat (MODE_CYC) @(posedge pclk_out);
        end

        // Connector released, formatter must freeze
        ctrl_write(make_ctrl(1'b1, EXP_SEL_OFF, EXTRA_OUT_YPBPR));
        @(negedge pclk_out);
        snap_rgb   = vga_rgb_o;
        snap_flags = {vga_hs_o, vga_vs_o, vga_blank_n_o, vga_sync_n_o};
        repeat (HOLD_CYC) @(negedge pclk_out);
        check_rgb("vga_rgb_o", vga_rgb_o, snap_rgb);
        check_word("{vga_hs_o,vga_vs_o,vga_blank_n_o,vga_sync_n_o}",
                   {vga_hs_o, vga_vs_o, vga_blank_n_o, vga_sync_n_o}, snap_flags);
        check_word("vga_oe_o", vga_oe_o, 1'b0);
        ctrl_write(32'h0);
        @(negedge pclk_out);
        check_word("hdmi_5v_en_o", hdmi_5v_en_o, 1'b0);
        check_word("vga_psave_n_o", vga_psave_n_o, 1'b0);
        repeat (4) @(negedge pclk_out);

        if (dut0.u_props.fail_cnt == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("%0d bound assertion failures", dut0.u_props.fail_cnt);
            $display("Simulation failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// File: compile.f
rtl/vidout_pkg.sv
rtl/vidout_apb_regs.sv
rtl/osd_overlay.sv
rtl/hdmi_tx_stage.sv
rtl/vga_dac_fmt.sv
rtl/vidout_top.sv
verif/vidout_props.sv
verif/tb_clkgen.sv
verif/tb_vidout.sv
